// ==== rtl/lsq_pkg.sv ====
package lsq_pkg;

  // ==================================================
  // widths and scalar types
  // ==================================================
  localparam int ADDR_W = 11;
  localparam int DATA_W = 64;
  localparam int ROB_W  = 5;
  localparam int TAG_W  = 2;

  // byte address, 2 KiB space
  typedef logic [ADDR_W-1:0] addr_t;
  // one doubleword, little-endian byte lanes
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ROB_W-1:0]  rob_idx_t;
  typedef logic [TAG_W-1:0]  br_tag_t;

  // access size, always naturally aligned
  typedef enum logic [1:0] {
    BYTE   = 2'd0,
    HALF   = 2'd1,
    WORD   = 2'd2,
    DOUBLE = 2'd3
  } mem_size_e;

  // memory port sequencing
  typedef enum logic {
    PORT_IDLE = 1'b0,
    PORT_DONE = 1'b1
  } port_state_e;

  // ==================================================
  // bundles
  // ==================================================
  typedef struct packed {
    logic      valid;
    logic      resolved;
    logic      committed;
    addr_t     addr;
    mem_size_e size;
    rob_idx_t  rob_idx;
    // already sitting in its byte lanes
    data_t     data;
  } sq_entry_t;

  typedef struct packed {
    addr_t     addr;
    mem_size_e size;
    data_t     data;
    rob_idx_t  rob_idx;
  } store_req_t;

  typedef struct packed {
    addr_t     addr;
    mem_size_e size;
  } load_req_t;

  // byte lanes touched by an aligned access
  function automatic logic [7:0] lane_mask(addr_t addr, mem_size_e size);
    logic [7:0] base;
    case (size)
      BYTE:    base = 8'h01;
      HALF:    base = 8'h03;
      WORD:    base = 8'h0f;
      default: base = 8'hff;
    endcase
    return base << addr[2:0];
  endfunction

endpackage

// ==== rtl/store_queue.sv ====
`timescale 1ns/1ps

module store_queue import lsq_pkg::*; #(
  parameter int SQ_SIZE = 8,
  localparam int IDX_W = $clog2(SQ_SIZE),
  localparam int CNT_W = $clog2(SQ_SIZE + 1)
) (
  input  logic             clock,
  input  logic             reset,
  // dispatch
  input  logic             enq_valid_i,
  input  mem_size_e        enq_size_i,
  input  rob_idx_t         enq_rob_i,
  // address and data from execute
  input  logic             resolve_valid_i,
  input  store_req_t       resolve_i,
  input  rob_idx_t         rob_head_i,
  // mispredict
  input  logic             restore_valid_i,
  input  logic [IDX_W-1:0] restore_tail_i,
  // memory port
  input  logic             store_accept_i,
  input  logic             store_done_i,
  output logic             store_req_valid_o,
  output store_req_t       store_req_o,
  // status
  output logic             full_o,
  output logic [CNT_W-1:0] free_slots_o,
  output logic [IDX_W-1:0] tail_o,
  output logic             rob_ready_o,
  output rob_idx_t         rob_ready_idx_o,
  // view for forwarding
  output sq_entry_t        entries_o [SQ_SIZE],
  output logic [IDX_W-1:0] head_o,
  output logic [CNT_W-1:0] count_o
);

  sq_entry_t        sq_q [SQ_SIZE];
  logic [IDX_W-1:0] head_q;
  logic [IDX_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;
  logic [CNT_W-1:0] squash_cnt;
  logic [SQ_SIZE-1:0] squash_vec;
  logic             in_flight_q;
  logic             do_enq;
  logic             do_pop;
  logic             commit_hit;
  logic [IDX_W-1:0] commit_idx;

  // wrap at SQ_SIZE
  function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] ptr);
    if (ptr == IDX_W'(SQ_SIZE - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ==================================================
  // squash range on restore
  // ==================================================
  // restored tail equal to tail means nothing younger exists
  always_comb begin
    squash_cnt = '0;
    if (restore_valid_i && (restore_tail_i != tail_q)) begin
      if (tail_q > restore_tail_i) begin
        squash_cnt = CNT_W'(tail_q - restore_tail_i);
      end else begin
        squash_cnt = CNT_W'(SQ_SIZE) - CNT_W'(restore_tail_i) + CNT_W'(tail_q);
      end
    end
  end

  // slot i is squashed when its distance from the restored tail is in range
  always_comb begin
    for (int i = 0; i < SQ_SIZE; i++) begin
      squash_vec[i] = ((i + SQ_SIZE - int'(restore_tail_i)) % SQ_SIZE) < int'(squash_cnt);
    end
  end

  // store at rob head, resolved, not yet marked
  always_comb begin
    commit_hit = 1'b0;
    commit_idx = '0;
    for (int i = 0; i < SQ_SIZE; i++) begin
      if (!commit_hit && sq_q[i].valid && sq_q[i].resolved && !sq_q[i].committed &&
          !squash_vec[i] && (sq_q[i].rob_idx == rob_head_i)) begin
        commit_hit = 1'b1;
        commit_idx = IDX_W'(i);
      end
    end
  end

  // restore wins over a new store
  assign do_enq  = enq_valid_i && !full_o && !restore_valid_i;
  // pop only for a store this queue handed over
  assign do_pop  = store_done_i && in_flight_q;
  assign count_d = count_q + CNT_W'(do_enq) - CNT_W'(do_pop) - squash_cnt;

  // ==================================================
  // state update
  // ==================================================
  always_ff @(posedge clock) begin
    if (reset) begin
      head_q      <= '0;
      tail_q      <= '0;
      count_q     <= '0;
      in_flight_q <= 1'b0;
      rob_ready_o <= 1'b0;
      for (int i = 0; i < SQ_SIZE; i++) begin
        sq_q[i].valid     <= 1'b0;
        sq_q[i].resolved  <= 1'b0;
        sq_q[i].committed <= 1'b0;
      end
    end else begin
      count_q     <= count_d;
      rob_ready_o <= commit_hit;
      if (commit_hit) begin
        sq_q[commit_idx].committed <= 1'b1;
        rob_ready_idx_o            <= rob_head_i;
      end
      // new store, address and data come later
      if (do_enq) begin
        sq_q[tail_q].valid     <= 1'b1;
        sq_q[tail_q].resolved  <= 1'b0;
        sq_q[tail_q].committed <= 1'b0;
        sq_q[tail_q].size      <= enq_size_i;
        sq_q[tail_q].rob_idx   <= enq_rob_i;
        tail_q                 <= next_ptr(tail_q);
      end
      // match by rob index
      if (resolve_valid_i && !restore_valid_i) begin
        for (int i = 0; i < SQ_SIZE; i++) begin
          if (sq_q[i].valid && (sq_q[i].rob_idx == resolve_i.rob_idx)) begin
            sq_q[i].addr     <= resolve_i.addr;
            sq_q[i].data     <= resolve_i.data;
            sq_q[i].resolved <= 1'b1;
          end
        end
      end
      // request held until the port takes it
      if (do_pop) begin
        in_flight_q <= 1'b0;
      end else if (store_req_valid_o && store_accept_i) begin
        in_flight_q <= 1'b1;
      end
      if (do_pop) begin
        sq_q[head_q].valid     <= 1'b0;
        sq_q[head_q].resolved  <= 1'b0;
        sq_q[head_q].committed <= 1'b0;
        head_q                 <= next_ptr(head_q);
      end
      // younger than the checkpoint, dropped
      if (restore_valid_i) begin
        tail_q <= restore_tail_i;
        for (int i = 0; i < SQ_SIZE; i++) begin
          if (squash_vec[i]) begin
            sq_q[i].valid     <= 1'b0;
            sq_q[i].resolved  <= 1'b0;
            sq_q[i].committed <= 1'b0;
          end
        end
      end
    end
  end

  // ==================================================
  // head request and status
  // ==================================================
  assign store_req_valid_o = sq_q[head_q].valid && sq_q[head_q].resolved &&
                             sq_q[head_q].committed;
  assign store_req_o.addr    = sq_q[head_q].addr;
  assign store_req_o.size    = sq_q[head_q].size;
  assign store_req_o.data    = sq_q[head_q].data;
  assign store_req_o.rob_idx = sq_q[head_q].rob_idx;

  assign full_o       = (count_q == CNT_W'(SQ_SIZE));
  assign free_slots_o = CNT_W'(SQ_SIZE) - count_q;
  assign tail_o       = tail_q;
  assign entries_o    = sq_q;
  assign head_o       = head_q;
  assign count_o      = count_q;

endmodule

// ==== rtl/store_forward.sv ====
`timescale 1ns/1ps

module store_forward import lsq_pkg::*; #(
  parameter int SQ_SIZE = 8,
  localparam int IDX_W = $clog2(SQ_SIZE),
  localparam int CNT_W = $clog2(SQ_SIZE + 1)
) (
  input  sq_entry_t        entries_i [SQ_SIZE],
  input  logic [IDX_W-1:0] head_i,
  input  logic [CNT_W-1:0] count_i,
  input  logic             load_valid_i,
  input  load_req_t        load_i,
  input  data_t            mem_rdata_i,
  output logic             load_fwd_o,
  output logic             load_pending_o,
  output data_t            load_data_o,
  output addr_t            mem_raddr_o
);

  logic [7:0] load_mask;
  logic       hit_fwd;
  logic       hit_pend;
  data_t      fwd_lanes;

  // move the addressed lanes to bit 0, zero the rest
  function automatic data_t extract(data_t lanes, addr_t addr, mem_size_e size);
    data_t shifted;
    shifted = lanes >> {addr[2:0], 3'b000};
    case (size)
      BYTE:    return data_t'(shifted[7:0]);
      HALF:    return data_t'(shifted[15:0]);
      WORD:    return data_t'(shifted[31:0]);
      default: return shifted;
    endcase
  endfunction

  assign load_mask   = lane_mask(load_i.addr, load_i.size);
  assign mem_raddr_o = load_i.addr;

  // ==================================================
  // youngest-first search
  // ==================================================
  always_comb begin
    int         pos;
    logic       found;
    logic [7:0] st_mask;
    hit_fwd   = 1'b0;
    hit_pend  = 1'b0;
    fwd_lanes = '0;
    found     = 1'b0;
    st_mask   = '0;
    for (int k = 0; k < SQ_SIZE; k++) begin
      // k = 0 is the slot just behind the tail
      pos = (int'(head_i) + int'(count_i) - 1 - k + SQ_SIZE) % SQ_SIZE;
      if (!found && (k < int'(count_i)) && entries_i[pos].valid) begin
        if (!entries_i[pos].resolved) begin
          // unknown address may alias
          hit_pend = 1'b1;
          found    = 1'b1;
        end else begin
          st_mask = lane_mask(entries_i[pos].addr, entries_i[pos].size);
          // aligned accesses only overlap inside one doubleword
          if ((entries_i[pos].addr[ADDR_W-1:3] == load_i.addr[ADDR_W-1:3]) &&
              |(st_mask & load_mask)) begin
            found = 1'b1;
            if ((load_mask & ~st_mask) == 8'h00) begin
              hit_fwd   = 1'b1;
              fwd_lanes = entries_i[pos].data;
            end else begin
              // partial cover, wait for drain
              hit_pend = 1'b1;
            end
          end
        end
      end
    end
  end

  assign load_fwd_o     = load_valid_i && hit_fwd;
  assign load_pending_o = load_valid_i && hit_pend;

  // forward, memory, or nothing while pending
  always_comb begin
    load_data_o = '0;
    if (load_valid_i && !hit_pend) begin
      if (hit_fwd) begin
        load_data_o = extract(fwd_lanes, load_i.addr, load_i.size);
      end else begin
        load_data_o = extract(mem_rdata_i, load_i.addr, load_i.size);
      end
    end
  end

endmodule

// ==== rtl/store_tail_checkpoint.sv ====
`timescale 1ns/1ps

module store_tail_checkpoint import lsq_pkg::*; #(
  parameter int SQ_SIZE    = 8,
  parameter int CKPT_DEPTH = 4,
  localparam int IDX_W = $clog2(SQ_SIZE)
) (
  input  logic             clock,
  input  logic             reset,
  // save on branch dispatch
  input  logic             branch_valid_i,
  input  br_tag_t          branch_tag_i,
  input  logic [IDX_W-1:0] tail_i,
  // lookup on mispredict
  input  br_tag_t          restore_tag_i,
  output logic [IDX_W-1:0] restore_tail_o
);

  // ==================================================
  // saved tails, one per branch tag
  // ==================================================
  logic [IDX_W-1:0] tails_q [CKPT_DEPTH];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < CKPT_DEPTH; i++) begin
        tails_q[i] <= '0;
      end
    end else if (branch_valid_i) begin
      // tail before any store in this same cycle
      tails_q[branch_tag_i] <= tail_i;
    end
  end

  // read straight through, queue applies it at the next edge
  assign restore_tail_o = tails_q[restore_tag_i];

endmodule

// ==== rtl/store_mem_port.sv ====
`timescale 1ns/1ps

module store_mem_port import lsq_pkg::*; #(
  parameter int MEM_DWORDS = 256,
  localparam int DW_W = $clog2(MEM_DWORDS)
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       store_req_valid_i,
  input  store_req_t store_req_i,
  input  addr_t      raddr_i,
  output logic       store_accept_o,
  output logic       store_done_o,
  output rob_idx_t   store_done_rob_o,
  output data_t      rdata_o
);

  data_t           mem_q [MEM_DWORDS];
  port_state_e     state_q;
  rob_idx_t        done_rob_q;
  logic            take;
  logic [DW_W-1:0] widx;
  logic [7:0]      wmask;

  assign store_accept_o = (state_q == PORT_IDLE);
  assign take           = store_req_valid_i && store_accept_o;
  // doubleword index above the lane offset
  assign widx           = store_req_i.addr[3 +: DW_W];
  assign wmask          = lane_mask(store_req_i.addr, store_req_i.size);

  // ==================================================
  // accept then done, one store per two cycles
  // ==================================================
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= PORT_IDLE;
    end else begin
      case (state_q)
        PORT_IDLE: if (take) state_q <= PORT_DONE;
        PORT_DONE: state_q <= PORT_IDLE;
        default:   state_q <= PORT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      done_rob_q <= store_req_i.rob_idx;
    end
  end

  assign store_done_o     = (state_q == PORT_DONE);
  assign store_done_rob_o = done_rob_q;

  // byte lane writes on the accept edge
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < MEM_DWORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (take) begin
      for (int b = 0; b < 8; b++) begin
        if (wmask[b]) begin
          mem_q[widx][8*b +: 8] <= store_req_i.data[8*b +: 8];
        end
      end
    end
  end

  // asynchronous read for loads
  assign rdata_o = mem_q[raddr_i[3 +: DW_W]];

endmodule

// ==== rtl/lsq_top.sv ====
`timescale 1ns/1ps

module lsq_top import lsq_pkg::*; #(
  parameter int SQ_SIZE    = 8,
  parameter int CKPT_DEPTH = 4,
  parameter int MEM_DWORDS = 256,
  localparam int IDX_W = $clog2(SQ_SIZE),
  localparam int CNT_W = $clog2(SQ_SIZE + 1)
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             enq_valid_i,
  input  mem_size_e        enq_size_i,
  input  rob_idx_t         enq_rob_i,
  output logic             full_o,
  output logic [CNT_W-1:0] free_slots_o,
  input  logic             resolve_valid_i,
  input  store_req_t       resolve_i,
  input  rob_idx_t         rob_head_i,
  output logic             rob_ready_o,
  output rob_idx_t         rob_ready_idx_o,
  input  logic             branch_valid_i,
  input  br_tag_t          branch_tag_i,
  input  logic             restore_valid_i,
  input  br_tag_t          restore_tag_i,
  input  logic             load_valid_i,
  input  load_req_t        load_i,
  output logic             load_fwd_o,
  output logic             load_pending_o,
  output data_t            load_data_o,
  output logic             store_done_o,
  output rob_idx_t         store_done_rob_o
);

  // ==================================================
  // internal nets
  // ==================================================
  logic             store_req_valid;
  store_req_t       store_req;
  logic             store_accept;
  logic [IDX_W-1:0] tail;
  logic [IDX_W-1:0] restore_tail;
  sq_entry_t        entries [SQ_SIZE];
  logic [IDX_W-1:0] head;
  logic [CNT_W-1:0] count;
  addr_t            mem_raddr;
  data_t            mem_rdata;

  store_queue #(.SQ_SIZE(SQ_SIZE)) u_queue (
    .clock            (clock),
    .reset            (reset),
    .enq_valid_i      (enq_valid_i),
    .enq_size_i       (enq_size_i),
    .enq_rob_i        (enq_rob_i),
    .resolve_valid_i  (resolve_valid_i),
    .resolve_i        (resolve_i),
    .rob_head_i       (rob_head_i),
    .restore_valid_i  (restore_valid_i),
    .restore_tail_i   (restore_tail),
    .store_accept_i   (store_accept),
    .store_done_i     (store_done_o),
    .store_req_valid_o(store_req_valid),
    .store_req_o      (store_req),
    .full_o           (full_o),
    .free_slots_o     (free_slots_o),
    .tail_o           (tail),
    .rob_ready_o      (rob_ready_o),
    .rob_ready_idx_o  (rob_ready_idx_o),
    .entries_o        (entries),
    .head_o           (head),
    .count_o          (count)
  );

  // load lookup against live stores
  store_forward #(.SQ_SIZE(SQ_SIZE)) u_forward (
    .entries_i     (entries),
    .head_i        (head),
    .count_i       (count),
    .load_valid_i  (load_valid_i),
    .load_i        (load_i),
    .mem_rdata_i   (mem_rdata),
    .load_fwd_o    (load_fwd_o),
    .load_pending_o(load_pending_o),
    .load_data_o   (load_data_o),
    .mem_raddr_o   (mem_raddr)
  );

  store_tail_checkpoint #(
    .SQ_SIZE   (SQ_SIZE),
    .CKPT_DEPTH(CKPT_DEPTH)
  ) u_ckpt (
    .clock         (clock),
    .reset         (reset),
    .branch_valid_i(branch_valid_i),
    .branch_tag_i  (branch_tag_i),
    .tail_i        (tail),
    .restore_tag_i (restore_tag_i),
    .restore_tail_o(restore_tail)
  );

  store_mem_port #(.MEM_DWORDS(MEM_DWORDS)) u_mem (
    .clock            (clock),
    .reset            (reset),
    .store_req_valid_i(store_req_valid),
    .store_req_i      (store_req),
    .raddr_i          (mem_raddr),
    .store_accept_o   (store_accept),
    .store_done_o     (store_done_o),
    .store_done_rob_o (store_done_rob_o),
    .rdata_o          (mem_rdata)
  );

endmodule

// ==== bench/lsq_tb.sv ====
`timescale 1ns/1ps

module lsq_tb import lsq_pkg::*;;

  localparam int SQ_SIZE    = 8;
  localparam int CKPT_DEPTH = 4;
  localparam int MEM_DWORDS = 256;
  localparam int CNT_W      = $clog2(SQ_SIZE + 1);
  localparam int NUM_OPS    = 600;
  localparam int MAX_SEQ    = 1024;

  logic             clock;
  logic             reset;
  logic             enq_valid_i;
  mem_size_e        enq_size_i;
  rob_idx_t         enq_rob_i;
  logic             full_o;
  logic [CNT_W-1:0] free_slots_o;
  logic             resolve_valid_i;
  store_req_t       resolve_i;
  rob_idx_t         rob_head_i;
  logic             rob_ready_o;
  rob_idx_t         rob_ready_idx_o;
  logic             branch_valid_i;
  br_tag_t          branch_tag_i;
  logic             restore_valid_i;
  br_tag_t          restore_tag_i;
  logic             load_valid_i;
  load_req_t        load_i;
  logic             load_fwd_o;
  logic             load_pending_o;
  data_t            load_data_o;
  logic             store_done_o;
  rob_idx_t         store_done_rob_o;

  // ==================================================
  // reference model state, indexed by program order
  // ==================================================
  rob_idx_t   st_rob  [MAX_SEQ];
  mem_size_e  st_size [MAX_SEQ];
  addr_t      st_addr [MAX_SEQ];
  data_t      st_data [MAX_SEQ];
  logic       st_res  [MAX_SEQ];
  logic       st_com  [MAX_SEQ];
  int         st_due  [MAX_SEQ];
  logic [7:0] mem_m   [2048];
  // live stores are head_seq .. next_seq-1
  int         head_seq;
  int         next_seq;
  int         saved_seq;
  int         d_res_seq;
  logic       br_out;
  int         br_timer;
  rob_idx_t   rob_ctr;
  logic       exp_ready;
  rob_idx_t   exp_ready_rob;
  logic       done_prev;
  int         last_done;
  logic       sweep;
  int         sweep_idx;
  integer     seed;
  int         errors;
  int         checks;
  int         cycle;

  lsq_top #(
    .SQ_SIZE   (SQ_SIZE),
    .CKPT_DEPTH(CKPT_DEPTH),
    .MEM_DWORDS(MEM_DWORDS)
  ) UUT (
    .clock           (clock),
    .reset           (reset),
    .enq_valid_i     (enq_valid_i),
    .enq_size_i      (enq_size_i),
    .enq_rob_i       (enq_rob_i),
    .full_o          (full_o),
    .free_slots_o    (free_slots_o),
    .resolve_valid_i (resolve_valid_i),
    .resolve_i       (resolve_i),
    .rob_head_i      (rob_head_i),
    .rob_ready_o     (rob_ready_o),
    .rob_ready_idx_o (rob_ready_idx_o),
    .branch_valid_i  (branch_valid_i),
    .branch_tag_i    (branch_tag_i),
    .restore_valid_i (restore_valid_i),
    .restore_tag_i   (restore_tag_i),
    .load_valid_i    (load_valid_i),
    .load_i          (load_i),
    .load_fwd_o      (load_fwd_o),
    .load_pending_o  (load_pending_o),
    .load_data_o     (load_data_o),
    .store_done_o    (store_done_o),
    .store_done_rob_o(store_done_rob_o)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // watchdog, sized from the random phase length
  initial begin
    #(NUM_OPS * 40 + 2000);
    $display("timeout: the store queue did not drain before the watchdog expired");
    $display("sim failed");
    $finish;
  end

  // ==================================================
  // helpers
  // ==================================================
  function automatic int rnd(input int n);
    return ($random(seed) & 32'h7fffffff) % n;
  endfunction

  function automatic int size_bytes(input mem_size_e size);
    case (size)
      BYTE:    return 1;
      HALF:    return 2;
      WORD:    return 4;
      default: return 8;
    endcase
  endfunction

  function automatic int model_count();
    return next_seq - head_seq;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp_val);
    errors++;
    $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp_val);
  endtask

  // apply the edge that just passed, using the inputs held since the last negedge
  task automatic update_model();
    int   hit;
    int   base;
    int   off;
    logic full_pre;
    hit      = -1;
    full_pre = (model_count() == SQ_SIZE);
    // commit looks at flags from before the edge
    for (int s = head_seq; s < next_seq; s++) begin
      if (hit < 0 && st_res[s] && !st_com[s] && (st_rob[s] == rob_head_i)) begin
        hit = s;
      end
    end
    // head store leaves on the done pulse
    if (done_prev) begin
      base = int'(st_addr[head_seq]);
      off  = int'(st_addr[head_seq][2:0]);
      for (int i = 0; i < size_bytes(st_size[head_seq]); i++) begin
        mem_m[base + i] = st_data[head_seq][8*(off + i) +: 8];
      end
      head_seq++;
    end
    if (enq_valid_i && !restore_valid_i && !full_pre) begin
      st_rob[next_seq]  = enq_rob_i;
      st_size[next_seq] = enq_size_i;
      st_res[next_seq]  = 1'b0;
      st_com[next_seq]  = 1'b0;
      st_due[next_seq]  = cycle + 1 + rnd(5);
      next_seq++;
      rob_ctr++;
    end
    if (resolve_valid_i && !restore_valid_i) begin
      st_res[d_res_seq]  = 1'b1;
      st_addr[d_res_seq] = resolve_i.addr;
      st_data[d_res_seq] = resolve_i.data;
    end
    // mispredict drops everything younger than the branch
    if (restore_valid_i) begin
      next_seq = saved_seq;
    end
    exp_ready = (hit >= 0);
    if (hit >= 0) begin
      st_com[hit]   = 1'b1;
      exp_ready_rob = st_rob[hit];
    end
  endtask

  task automatic check_outputs();
    checks++;
    if (free_slots_o !== CNT_W'(SQ_SIZE - model_count())) begin
      report_mismatch("free_slots_o", 64'(free_slots_o), 64'(SQ_SIZE - model_count()));
    end
    if (full_o !== (model_count() == SQ_SIZE)) begin
      report_mismatch("full_o", 64'(full_o), 64'(model_count() == SQ_SIZE));
    end
    if (rob_ready_o !== exp_ready) begin
      report_mismatch("rob_ready_o", 64'(rob_ready_o), 64'(exp_ready));
    end
    if (exp_ready && (rob_ready_idx_o !== exp_ready_rob)) begin
      report_mismatch("rob_ready_idx_o", 64'(rob_ready_idx_o), 64'(exp_ready_rob));
    end
    // drains must follow program order of committed stores
    if (store_done_o === 1'b1) begin
      if ((model_count() == 0) || !st_com[head_seq]) begin
        errors++;
        $display("store done pulse at %0t with no committed store at the queue head", $time);
      end else if (store_done_rob_o !== st_rob[head_seq]) begin
        report_mismatch("store_done_rob_o", 64'(store_done_rob_o), 64'(st_rob[head_seq]));
      end
      if (cycle - last_done < 2) begin
        errors++;
        $display("store done pulses less than 2 cycles apart at %0t", $time);
      end
      last_done = cycle;
    end
    done_prev = (store_done_o === 1'b1) && (model_count() > 0);
  endtask

  // ==================================================
  // stimulus
  // ==================================================
  task automatic drive_inputs(input logic allow_enq);
    int bytes;
    int s;
    restore_valid_i = 1'b0;
    branch_valid_i  = 1'b0;
    enq_valid_i     = 1'b0;
    resolve_valid_i = 1'b0;
    // one branch in flight at a time, mispredicted half the time
    if (br_out) begin
      br_timer--;
      if (br_timer == 0) begin
        br_out          = 1'b0;
        restore_valid_i = (rnd(2) == 1);
      end
    end else if (allow_enq && (rnd(12) == 0)) begin
      branch_valid_i = 1'b1;
      branch_tag_i   = br_tag_t'(rnd(4));
      restore_tag_i  = branch_tag_i;
      saved_seq      = next_seq;
      br_out         = 1'b1;
      br_timer       = 3 + rnd(8);
    end
    // dispatch stalls before the tail could wrap onto the checkpoint
    if (allow_enq && (rnd(2) == 1) &&
        !(br_out && (next_seq - saved_seq >= SQ_SIZE - 1))) begin
      enq_valid_i = 1'b1;
      enq_size_i  = mem_size_e'(rnd(4));
      enq_rob_i   = rob_ctr;
    end
    // oldest store past its delay gets address and data
    if (!restore_valid_i) begin
      for (s = head_seq; s < next_seq; s++) begin
        if (!resolve_valid_i && !st_res[s] && (st_due[s] <= cycle)) begin
          resolve_valid_i   = 1'b1;
          d_res_seq         = s;
          bytes             = size_bytes(st_size[s]);
          resolve_i.addr    = addr_t'((rnd(64) / bytes) * bytes);
          resolve_i.size    = st_size[s];
          resolve_i.data    = {$random(seed), $random(seed)};
          resolve_i.rob_idx = st_rob[s];
        end
      end
    end
    // rob head parks far from any live index when nothing may commit
    rob_head_i = rob_ctr + 5'd16;
    s = head_seq;
    while ((s < next_seq) && st_com[s]) begin
      s++;
    end
    if ((s < next_seq) && !((br_out || restore_valid_i) && (s >= saved_seq))) begin
      rob_head_i = st_rob[s];
    end
    // idle load slots now and then
    load_valid_i = sweep || (rnd(4) != 0);
    if (sweep) begin
      load_i.size = DOUBLE;
      load_i.addr = addr_t'(sweep_idx * 8);
    end else begin
      load_i.size = mem_size_e'(rnd(4));
      bytes       = size_bytes(load_i.size);
      load_i.addr = addr_t'((rnd(64) / bytes) * bytes);
    end
  endtask

  task automatic check_load();
    int    bytes;
    int    off;
    int    s;
    int    fs;
    int    so;
    int    sb;
    logic  pend;
    logic  fwd;
    data_t exp_data;
    bytes = size_bytes(load_i.size);
    off   = int'(load_i.addr[2:0]);
    pend  = 1'b0;
    fwd   = 1'b0;
    fs    = -1;
    s     = next_seq - 1;
    // youngest first, the first unresolved or overlapping store decides
    while ((s >= head_seq) && (fs < 0)) begin
      if (!st_res[s]) begin
        pend = 1'b1;
        fs   = s;
      end else begin
        so = int'(st_addr[s][2:0]);
        sb = size_bytes(st_size[s]);
        if ((st_addr[s][10:3] == load_i.addr[10:3]) && (so < off + bytes) &&
            (off < so + sb)) begin
          fs = s;
          if ((so <= off) && (off + bytes <= so + sb)) begin
            fwd = 1'b1;
          end else begin
            pend = 1'b1;
          end
        end
      end
      s--;
    end
    exp_data = '0;
    for (int i = 0; i < bytes; i++) begin
      if (fwd) begin
        exp_data[8*i +: 8] = st_data[fs][8*(off + i) +: 8];
      end else begin
        exp_data[8*i +: 8] = mem_m[int'(load_i.addr) + i];
      end
    end
    // no query, all load outputs quiet
    if (!load_valid_i) begin
      pend     = 1'b0;
      fwd      = 1'b0;
      exp_data = '0;
    end
    checks++;
    if (load_pending_o !== pend) begin
      report_mismatch("load_pending_o", 64'(load_pending_o), 64'(pend));
    end
    if (load_fwd_o !== fwd) begin
      report_mismatch("load_fwd_o", 64'(load_fwd_o), 64'(fwd));
    end
    if (!pend && (load_data_o !== exp_data)) begin
      report_mismatch("load_data_o", load_data_o, exp_data);
    end
  endtask

  // one clock: check the last edge, then drive the next one
  task automatic step_cycle(input logic allow_enq);
    @(negedge clock);
    cycle++;
    update_model();
    check_outputs();
    drive_inputs(allow_enq);
    #1;
    check_load();
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    seed            = 79449;
    errors          = 0;
    checks          = 0;
    cycle           = 0;
    head_seq        = 0;
    next_seq        = 0;
    saved_seq       = 0;
    d_res_seq       = 0;
    br_out          = 1'b0;
    br_timer        = 0;
    rob_ctr         = '0;
    exp_ready       = 1'b0;
    exp_ready_rob   = '0;
    done_prev       = 1'b0;
    last_done       = -10;
    sweep           = 1'b0;
    sweep_idx       = 0;
    for (int i = 0; i < 2048; i++) begin
      mem_m[i] = 8'h00;
    end
    reset           = 1'b1;
    enq_valid_i     = 1'b0;
    enq_size_i      = BYTE;
    enq_rob_i       = '0;
    resolve_valid_i = 1'b0;
    resolve_i       = '0;
    rob_head_i      = 5'd16;
    branch_valid_i  = 1'b0;
    branch_tag_i    = '0;
    restore_valid_i = 1'b0;
    restore_tag_i   = '0;
    load_valid_i    = 1'b0;
    load_i          = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    repeat (NUM_OPS) step_cycle(1'b1);
    // no new stores, let the branch settle and the queue empty
    while ((model_count() != 0) || br_out) begin
      step_cycle(1'b0);
    end
    // every doubleword the stores could reach
    sweep = 1'b1;
    for (sweep_idx = 0; sweep_idx < 8; sweep_idx++) begin
      step_cycle(1'b0);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
rtl/lsq_pkg.sv
rtl/store_queue.sv
rtl/store_forward.sv
rtl/store_tail_checkpoint.sv
rtl/store_mem_port.sv
rtl/lsq_top.sv
bench/lsq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the store queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module lsq_tb -f verilog.f -o lsq_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

output=$(./obj_dir/lsq_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
